/* all.f */
+incdir+verilog
verilog/dispatch_pkg.sv
verilog/decode.sv
verilog/fetch_packer.sv
verilog/inst_queue.sv
verilog/dispatch.sv
verilog/dispatch_stage.sv
verification/tb_dispatch_stage.sv

/* Makefile */
# Verilator build and run for the dispatch stage testbench.

VERILATOR ?= verilator
TOP       ?= tb_dispatch_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) verilog/dispatch_cfg.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the log holds the pass line.
run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_dispatch_stage.sv */
`default_nettype none
`include "dispatch_cfg.svh"

module tb_dispatch_stage;

    import dispatch_pkg::*;

    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_CYCLES  = 3;
    localparam int DRAIN_MAX     = 40;
    localparam int RANDOM_CYCLES = 300;
    // Budget per test, drains included, summed into the watchdog limit.
    localparam int CYCLE_LIMIT = RESET_CYCLES + 2 + (4 + DRAIN_MAX) + (12 + DRAIN_MAX)
                               + (16 + 3 * DRAIN_MAX) + (16 + 2 * DRAIN_MAX)
                               + (RANDOM_CYCLES + DRAIN_MAX) + 20;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;    // Not in the table, decodes as other.

    logic                                  clock;
    logic                                  rst_n;
    logic                                  fetch_valid;
    logic [`DISPATCH_WIDTH-1:0]            fetch_mask;
    logic [`DISPATCH_WIDTH-1:0][31:0]      fetch_insts;
    logic [`COUNT_W-1:0]                   rob_open;
    logic [`COUNT_W-1:0]                   rs_open;
    logic                                  bs_full;
    logic                                  fetch_stall;
    logic [`COUNT_W-1:0]                   num_dispatch;
    logic [`DISPATCH_WIDTH-1:0]            out_valid;
    logic [`DISPATCH_WIDTH-1:0][31:0]      out_insts;
    op_class_e [`DISPATCH_WIDTH-1:0]       out_op;
    logic [`DISPATCH_WIDTH-1:0][4:0]       out_rd;
    logic [`DISPATCH_WIDTH-1:0][4:0]       out_rs1;
    logic [`DISPATCH_WIDTH-1:0][4:0]       out_rs2;

    logic [31:0]  model_q [$];                          // Queue contents, oldest first.
    logic [31:0]  pend_insts [`DISPATCH_WIDTH];          // Group held in the packer.
    int           pend_count;
    int           exp_count;
    logic [31:0]  rng_state;
    logic [9:0]   serial;
    int           checks;
    int           fails;
    int           cycle_count;
    logic         saw_stall;

    dispatch_stage u_dispatch_stage (
        .clock        (clock),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch_mask   (fetch_mask),
        .fetch_insts  (fetch_insts),
        .rob_open     (rob_open),
        .rs_open      (rs_open),
        .bs_full      (bs_full),
        .fetch_stall  (fetch_stall),
        .num_dispatch (num_dispatch),
        .out_valid    (out_valid),
        .out_insts    (out_insts),
        .out_op       (out_op),
        .out_rd       (out_rd),
        .out_rs1      (out_rs1),
        .out_rs2      (out_rs2)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // A serial number in the funct fields keeps every word unique.
    function automatic logic [31:0] make_word(input logic [6:0] opc, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2);
        serial = serial + 10'd1;
        return {serial[6:0], rs2, rs1, serial[9:7], rd, opc};
    endfunction

    function automatic logic [6:0] pick_opcode(input logic [3:0] sel);
        case (sel)
            4'd0:         return OPC_LUI;
            4'd1:         return OPC_AUIPC;
            4'd2, 4'd12:  return OPC_JAL;
            4'd3:         return OPC_JALR;
            4'd4, 4'd11:  return OPC_BRANCH;
            4'd5:         return OPC_LOAD;
            4'd6:         return OPC_STORE;
            4'd7:         return OPC_OP_IMM;
            4'd8, 4'd13:  return OPC_OP;
            4'd9:         return OPC_SYSTEM;
            default:      return OPC_FENCE;
        endcase
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] r;
        r = rand32();
        return make_word(pick_opcode(r[31:28]), r[4:0], r[9:5], r[14:10]);
    endfunction

    // Decode table of the core, from major opcode to class and used register fields.
    function automatic void ref_decode(input logic [31:0] inst, output op_class_e cls,
                                       output logic [4:0] rd, output logic [4:0] rs1,
                                       output logic [4:0] rs2);
        logic use_rd;
        logic use_rs1;
        logic use_rs2;
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        cls     = op_other;
        case (inst[6:0])
            OPC_LUI, OPC_AUIPC: begin
                cls     = op_alu;
                use_rs1 = 1'b0;
            end
            OPC_JAL: begin
                cls     = op_jump;
                use_rs1 = 1'b0;
            end
            OPC_JALR:           cls = op_jump;
            OPC_BRANCH: begin
                cls     = op_cond_branch;
                use_rd  = 1'b0;
                use_rs2 = 1'b1;
            end
            OPC_LOAD:           cls = op_load;
            OPC_STORE: begin
                cls     = op_store;
                use_rd  = 1'b0;
                use_rs2 = 1'b1;
            end
            OPC_OP_IMM:         cls = op_alu;
            OPC_OP: begin
                cls     = op_alu;
                use_rs2 = 1'b1;
            end
            OPC_SYSTEM:         cls = op_other;
            default: begin
                use_rd  = 1'b0;
                use_rs1 = 1'b0;
            end
        endcase
        rd  = use_rd  ? inst[11:7]  : 5'd0;
        rs1 = use_rs1 ? inst[19:15] : 5'd0;
        rs2 = use_rs2 ? inst[24:20] : 5'd0;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            fails++;
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Expected outputs for this cycle from the model and the live limits.
    task automatic check_outputs();
        int         limit;
        logic       stop;
        op_class_e  cls;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        limit = (model_q.size() < `DISPATCH_WIDTH) ? model_q.size() : `DISPATCH_WIDTH;
        if (int'(rob_open) < limit) limit = int'(rob_open);
        if (int'(rs_open) < limit) limit = int'(rs_open);
        stop      = 1'b0;
        exp_count = 0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            cls = op_alu;
            rd  = 5'd0;
            rs1 = 5'd0;
            rs2 = 5'd0;
            if (!stop && i < limit) begin
                ref_decode(model_q[i], cls, rd, rs1, rs2);
                if ((cls == op_cond_branch || cls == op_jump) && (i > 0 || bs_full)) begin
                    stop = 1'b1;
                end
            end
            if (stop || i >= limit) begin
                check_value(32'(out_valid[i]), 32'd0, $sformatf("slot %0d valid", i));
                check_value(out_insts[i], 32'd0, $sformatf("slot %0d word", i));
                cls = op_alu;
                rd  = 5'd0;
                rs1 = 5'd0;
                rs2 = 5'd0;
            end else begin
                exp_count++;
                check_value(32'(out_valid[i]), 32'd1, $sformatf("slot %0d valid", i));
                check_value(out_insts[i], model_q[i], $sformatf("slot %0d word", i));
            end
            check_value(32'(out_op[i]), 32'(cls), $sformatf("slot %0d class", i));
            check_value(32'(out_rd[i]), 32'(rd), $sformatf("slot %0d rd", i));
            check_value(32'(out_rs1[i]), 32'(rs1), $sformatf("slot %0d rs1", i));
            check_value(32'(out_rs2[i]), 32'(rs2), $sformatf("slot %0d rs2", i));
        end
        check_value(32'(num_dispatch), 32'(exp_count), "num_dispatch");
        check_value(32'(fetch_stall),
                    32'((`QUEUE_DEPTH - model_q.size()) < (`DISPATCH_WIDTH + pend_count)),
                    "fetch_stall");
    endtask

    // What the next rising edge does to the queue and the packer.
    task automatic advance_model();
        int free_now;
        free_now = `QUEUE_DEPTH - model_q.size();
        for (int i = 0; i < exp_count; i++) void'(model_q.pop_front());
        if (pend_count != 0) begin
            checks++;
            assert (pend_count <= free_now) else begin
                fails++;
                $display("A fetch group of %0d words was lost to a full queue at %0t",
                         pend_count, $time);
            end
            if (pend_count <= free_now) begin
                for (int i = 0; i < pend_count; i++) model_q.push_back(pend_insts[i]);
            end
        end
        pend_count = 0;
        if (fetch_valid) begin
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                if (fetch_mask[i]) begin
                    pend_insts[pend_count] = fetch_insts[i];
                    pend_count++;
                end
            end
        end
    endtask

    // Inputs change just after the rising edge, so the falling edge sees settled outputs.
    always @(negedge clock) begin
        if (!rst_n) begin
            model_q.delete();
            pend_count = 0;
        end else begin
            check_outputs();
            advance_model();
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: run still busy after %0d cycles", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic step();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic set_limits(input int rob, input int rs, input logic full);
        rob_open = (`COUNT_W)'(rob);
        rs_open  = (`COUNT_W)'(rs);
        bs_full  = full;
    endtask

    // A strobe is only raised while the queue can take it.
    task automatic fetch_group(input logic [`DISPATCH_WIDTH-1:0] mask,
                               input logic [`DISPATCH_WIDTH-1:0][31:0] words);
        step();
        fetch_valid = !fetch_stall;
        fetch_mask  = mask;
        fetch_insts = words;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            step();
            fetch_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        idle_cycles(1);
        while ((model_q.size() != 0 || pend_count != 0) && n < DRAIN_MAX) begin
            idle_cycles(1);
            n++;
        end
        if (model_q.size() != 0 || pend_count != 0) begin
            fails++;
            $display("Queue did not drain within %0d cycles at %0t", DRAIN_MAX, $time);
        end
    endtask

    task automatic test_done(input string name);
        $display("Test %s finished, failures so far %0d", name, fails);
    endtask

    initial begin
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_mask  = '0;
        fetch_insts = '0;
        set_limits(`DISPATCH_WIDTH, `DISPATCH_WIDTH, 1'b0);
        rng_state   = 32'ha5eb;
        serial      = '0;
        checks      = 0;
        fails       = 0;
        cycle_count = 0;
        pend_count  = 0;
        exp_count   = 0;
        saw_stall   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        step();
        check_value(32'(num_dispatch), 32'd0, "num_dispatch after reset");
        check_value(32'(out_valid), 32'd0, "out_valid after reset");
        check_value(32'(fetch_stall), 32'd0, "fetch_stall after reset");
        test_done("reset_values");

        fetch_group(4'b1111, {make_word(OPC_LUI, 5'd4, 5'd9, 5'd9),
                              make_word(OPC_STORE, 5'd7, 5'd3, 5'd6),
                              make_word(OPC_LOAD, 5'd5, 5'd2, 5'd8),
                              make_word(OPC_OP, 5'd1, 5'd2, 5'd3)});
        idle_cycles(2);
        check_value(32'(num_dispatch), 32'd4, "full group two edges after the strobe");
        wait_drain();
        test_done("plain_flow");

        set_limits(0, 4, 1'b0);
        fetch_group(4'b1111, {random_word(), random_word(), random_word(), random_word()});
        fetch_group(4'b1111, {make_word(OPC_OP_IMM, 5'd1, 5'd1, 5'd0),
                              make_word(OPC_OP, 5'd2, 5'd3, 5'd4),
                              make_word(OPC_SYSTEM, 5'd5, 5'd6, 5'd7),
                              make_word(OPC_FENCE, 5'd8, 5'd9, 5'd10)});
        idle_cycles(3);
        check_value(32'(num_dispatch), 32'd0, "dispatch with no rob entries");
        set_limits(4, 0, 1'b0);
        idle_cycles(2);
        set_limits(3, 2, 1'b0);
        idle_cycles(1);
        set_limits(1, 4, 1'b0);
        idle_cycles(1);
        set_limits(4, 4, 1'b0);
        wait_drain();
        test_done("resource_limit");

        fetch_group(4'b1111, {make_word(OPC_JAL, 5'd1, 5'd0, 5'd0),
                              make_word(OPC_LOAD, 5'd2, 5'd3, 5'd0),
                              make_word(OPC_OP, 5'd4, 5'd5, 5'd6),
                              make_word(OPC_BRANCH, 5'd0, 5'd7, 5'd8)});
        wait_drain();
        fetch_group(4'b1111, {make_word(OPC_OP, 5'd9, 5'd1, 5'd2),
                              make_word(OPC_BRANCH, 5'd0, 5'd3, 5'd4),
                              make_word(OPC_STORE, 5'd0, 5'd5, 5'd6),
                              make_word(OPC_OP, 5'd7, 5'd8, 5'd9)});
        wait_drain();
        set_limits(4, 4, 1'b1);
        fetch_group(4'b1111, {random_word(), make_word(OPC_OP, 5'd1, 5'd2, 5'd3),
                              make_word(OPC_OP, 5'd4, 5'd5, 5'd6),
                              make_word(OPC_JALR, 5'd1, 5'd2, 5'd0)});
        idle_cycles(5);
        check_value(32'(num_dispatch), 32'd0, "dispatch with branch stack full");
        set_limits(4, 4, 1'b0);
        wait_drain();
        test_done("branch_rule");

        fetch_group(4'b0101, {random_word(), random_word(), random_word(), random_word()});
        fetch_group(4'b1000, {random_word(), random_word(), random_word(), random_word()});
        fetch_group(4'b0000, {random_word(), random_word(), random_word(), random_word()});
        fetch_group(4'b1110, {random_word(), random_word(), random_word(), random_word()});
        wait_drain();
        set_limits(0, 4, 1'b0);
        for (int i = 0; i < 10; i++) begin
            if (fetch_stall) saw_stall = 1'b1;
            fetch_group(4'b1111, {random_word(), random_word(), random_word(), random_word()});
        end
        check_value(32'(saw_stall), 32'd1, "fetch_stall rose under back-pressure");
        set_limits(4, 4, 1'b0);
        wait_drain();
        test_done("packing_backpressure");

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            set_limits(int'(rand32() % 5), int'(rand32() % 5), rand32() % 4 == 0);
            fetch_group((`DISPATCH_WIDTH)'(rand32() % 16),
                        {random_word(), random_word(), random_word(), random_word()});
            if (rand32() % 3 == 0) fetch_valid = 1'b0;
        end
        set_limits(4, 4, 1'b0);
        wait_drain();
        test_done("random_mix");

        $display("Checks run: %0d, failures: %0d", checks, fails);
        if (fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/dispatch_stage.sv */
`default_nettype none
`include "dispatch_cfg.svh"

module dispatch_stage (
    input  wire logic                                         clock,
    input  wire logic                                         rst_n,
    input  wire logic                                         fetch_valid,
    input  wire logic [`DISPATCH_WIDTH-1:0]                   fetch_mask,
    input  wire logic [`DISPATCH_WIDTH-1:0][31:0]             fetch_insts,
    input  wire logic [`COUNT_W-1:0]                          rob_open,
    input  wire logic [`COUNT_W-1:0]                          rs_open,
    input  wire logic                                         bs_full,
    output logic                                              fetch_stall,
    output logic      [`COUNT_W-1:0]                          num_dispatch,
    output logic      [`DISPATCH_WIDTH-1:0]                   out_valid,
    output logic      [`DISPATCH_WIDTH-1:0][31:0]             out_insts,
    output dispatch_pkg::op_class_e [`DISPATCH_WIDTH-1:0]     out_op,
    output logic      [`DISPATCH_WIDTH-1:0][4:0]              out_rd,
    output logic      [`DISPATCH_WIDTH-1:0][4:0]              out_rs1,
    output logic      [`DISPATCH_WIDTH-1:0][4:0]              out_rs2
);

    logic [`COUNT_W-1:0]              push_count;
    logic [`DISPATCH_WIDTH-1:0][31:0] push_insts;
    logic [`COUNT_W-1:0]              window_count;
    logic [`DISPATCH_WIDTH-1:0][31:0] window_insts;

    fetch_packer u_fetch_packer (
        .clock       (clock),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_mask  (fetch_mask),
        .fetch_insts (fetch_insts),
        .push_count  (push_count),
        .push_insts  (push_insts)
    );

    // What dispatch takes this cycle is popped on the next edge.
    inst_queue u_inst_queue (
        .clock        (clock),
        .rst_n        (rst_n),
        .push_count   (push_count),
        .push_insts   (push_insts),
        .pop_count    (num_dispatch),
        .window_count (window_count),
        .window_insts (window_insts),
        .fetch_stall  (fetch_stall)
    );

    dispatch u_dispatch (
        .window_count (window_count),
        .window_insts (window_insts),
        .rob_open     (rob_open),
        .rs_open      (rs_open),
        .bs_full      (bs_full),
        .num_dispatch (num_dispatch),
        .out_valid    (out_valid),
        .out_insts    (out_insts),
        .out_op       (out_op),
        .out_rd       (out_rd),
        .out_rs1      (out_rs1),
        .out_rs2      (out_rs2)
    );

endmodule

`default_nettype wire

/* verilog/dispatch.sv */
`default_nettype none
`include "dispatch_cfg.svh"

module dispatch (
    input  wire logic [`COUNT_W-1:0]                          window_count,
    input  wire logic [`DISPATCH_WIDTH-1:0][31:0]             window_insts,
    input  wire logic [`COUNT_W-1:0]                          rob_open,
    input  wire logic [`COUNT_W-1:0]                          rs_open,
    input  wire logic                                         bs_full,
    output logic      [`COUNT_W-1:0]                          num_dispatch,
    output logic      [`DISPATCH_WIDTH-1:0]                   out_valid,
    output logic      [`DISPATCH_WIDTH-1:0][31:0]             out_insts,
    output dispatch_pkg::op_class_e [`DISPATCH_WIDTH-1:0]     out_op,
    output logic      [`DISPATCH_WIDTH-1:0][4:0]              out_rd,
    output logic      [`DISPATCH_WIDTH-1:0][4:0]              out_rs1,
    output logic      [`DISPATCH_WIDTH-1:0][4:0]              out_rs2
);

    import dispatch_pkg::*;

    op_class_e [`DISPATCH_WIDTH-1:0]  dec_op;
    logic [`DISPATCH_WIDTH-1:0][4:0]  dec_rd;
    logic [`DISPATCH_WIDTH-1:0][4:0]  dec_rs1;
    logic [`DISPATCH_WIDTH-1:0][4:0]  dec_rs2;
    logic [`COUNT_W-1:0]              res_open;
    logic [`COUNT_W-1:0]              limit;

    for (genvar g = 0; g < `DISPATCH_WIDTH; g++) begin : g_slot
        decode u_decode (
            .inst     (window_insts[g]),
            .op_class (dec_op[g]),
            .rd       (dec_rd[g]),
            .rs1      (dec_rs1[g]),
            .rs2      (dec_rs2[g])
        );
    end

    assign res_open = (rob_open < rs_open) ? rob_open : rs_open;
    assign limit    = (window_count < res_open) ? window_count : res_open;

    // Taken slots are always a run from slot 0, so the count doubles as the pop.
    always_comb begin
        logic walk_done;
        walk_done    = 1'b0;
        num_dispatch = '0;
        out_valid    = '0;
        out_insts    = '0;
        out_rd       = '0;
        out_rs1      = '0;
        out_rs2      = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            out_op[i] = op_alu;                     // Encodes as zero.
        end
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (!walk_done && i < int'(limit)) begin
                if (is_branch(dec_op[i]) && (i != 0 || bs_full)) begin
                    walk_done = 1'b1;               // Branch ends the group here.
                end else begin
                    out_valid[i] = 1'b1;
                    out_insts[i] = window_insts[i];
                    out_op[i]    = dec_op[i];
                    out_rd[i]    = dec_rd[i];
                    out_rs1[i]   = dec_rs1[i];
                    out_rs2[i]   = dec_rs2[i];
                    num_dispatch = num_dispatch + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/inst_queue.sv */
`default_nettype none
`include "dispatch_cfg.svh"

module inst_queue (
    input  wire logic                                  clock,
    input  wire logic                                  rst_n,
    input  wire logic [`COUNT_W-1:0]                   push_count,
    input  wire logic [`DISPATCH_WIDTH-1:0][31:0]      push_insts,
    input  wire logic [`COUNT_W-1:0]                   pop_count,
    output logic      [`COUNT_W-1:0]                   window_count,
    output logic      [`DISPATCH_WIDTH-1:0][31:0]      window_insts,
    output logic                                       fetch_stall
);

    logic [31:0]          mem [`QUEUE_DEPTH];
    logic [`PTR_W-1:0]    head;                     // Oldest entry.
    logic [`PTR_W-1:0]    tail;                     // Next free entry.
    logic [`OCC_W-1:0]    occ;                      // Number of valid entries.
    logic [`OCC_W-1:0]    free_slots;
    logic [`OCC_W-1:0]    push_amt;
    logic [`OCC_W-1:0]    pop_amt;
    logic                 push_ok;

    assign free_slots = (`OCC_W)'(`QUEUE_DEPTH) - occ;

    // A group that does not fit is refused as a whole.
    assign push_ok  = (push_count != '0) && ((`OCC_W)'(push_count) <= free_slots);
    assign push_amt = push_ok ? (`OCC_W)'(push_count) : '0;
    assign pop_amt  = (`OCC_W)'(pop_count);

    // The group already sitting in the packer lands on the next edge, so it counts
    // against the free space. A strobe taken while this is low always fits.
    assign fetch_stall = free_slots < ((`OCC_W)'(`DISPATCH_WIDTH) + (`OCC_W)'(push_count));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            occ  <= '0;
        end else begin
            head <= head + (`PTR_W)'(pop_count);    // Dispatch never pops more than the window.
            tail <= tail + (`PTR_W)'(push_amt);
            occ  <= occ + push_amt - pop_amt;
        end
    end

    // Storage write, up to a full group per cycle starting at the tail.
    always_ff @(posedge clock) begin
        if (push_ok) begin
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                if (i < int'(push_count)) begin
                    mem[tail + (`PTR_W)'(i)] <= push_insts[i];
                end
            end
        end
    end

    // The window shows at most one group, oldest entry in slot 0.
    always_comb begin
        if (occ >= (`OCC_W)'(`DISPATCH_WIDTH)) begin
            window_count = (`COUNT_W)'(`DISPATCH_WIDTH);
        end else begin
            window_count = (`COUNT_W)'(occ);
        end
    end

    always_comb begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (i < int'(window_count)) begin
                window_insts[i] = mem[head + (`PTR_W)'(i)];
            end else begin
                window_insts[i] = '0;               // Empty slots read as zero.
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_packer.sv */
`default_nettype none
`include "dispatch_cfg.svh"

module fetch_packer (
    input  wire logic                                  clock,
    input  wire logic                                  rst_n,
    input  wire logic                                  fetch_valid,
    input  wire logic [`DISPATCH_WIDTH-1:0]            fetch_mask,
    input  wire logic [`DISPATCH_WIDTH-1:0][31:0]      fetch_insts,
    output logic      [`COUNT_W-1:0]                   push_count,
    output logic      [`DISPATCH_WIDTH-1:0][31:0]      push_insts
);

    logic [`COUNT_W-1:0]              packed_count;
    logic [`DISPATCH_WIDTH-1:0][31:0] packed_insts;

    // Walk the slots in order and drop each masked-in word into the next free low slot.
    always_comb begin
        packed_count = '0;
        packed_insts = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (fetch_mask[i]) begin
                packed_insts[packed_count] = fetch_insts[i];    // Order is kept.
                packed_count = packed_count + 1'b1;
            end
        end
    end

    // Number of words in the registered group.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            push_count <= '0;
        end else if (fetch_valid) begin
            push_count <= packed_count;
        end else begin
            push_count <= '0;                                   // No strobe, nothing to push.
        end
    end

    // Packed words, valid below push_count.
    always_ff @(posedge clock) begin
        if (fetch_valid) begin
            push_insts <= packed_insts;
        end
    end

endmodule

`default_nettype wire

/* verilog/decode.sv */
`default_nettype none

module decode (
    input  wire logic [31:0]              inst,
    output dispatch_pkg::op_class_e       op_class,
    output logic      [4:0]               rd,
    output logic      [4:0]               rs1,
    output logic      [4:0]               rs2
);

    import dispatch_pkg::*;

    opcode_e opcode;

    assign opcode = opcode_e'(inst[6:0]);

    // Start from the raw fields and clear what the class has no use for.
    always_comb begin
        op_class = op_other;
        rd       = inst[11:7];
        rs1      = inst[19:15];
        rs2      = inst[24:20];
        case (opcode)
            opc_lui, opc_auipc: begin
                op_class = op_alu;                  // Upper immediate, no sources.
                rs1      = '0;
                rs2      = '0;
            end
            opc_jal: begin
                op_class = op_jump;
                rs1      = '0;
                rs2      = '0;
            end
            opc_jalr: begin
                op_class = op_jump;                 // Target comes from rs1.
                rs2      = '0;
            end
            opc_branch: begin
                op_class = op_cond_branch;
                rd       = '0;                      // Compares two sources, writes nothing.
            end
            opc_load: begin
                op_class = op_load;
                rs2      = '0;
            end
            opc_store: begin
                op_class = op_store;
                rd       = '0;
            end
            opc_op_imm: begin
                op_class = op_alu;
                rs2      = '0;                      // Bits 24:20 are immediate here.
            end
            opc_op: begin
                op_class = op_alu;
            end
            opc_system: begin
                op_class = op_other;                // CSR ops keep rd and rs1.
                rs2      = '0;
            end
            default: begin
                op_class = op_other;
                rd       = '0;
                rs1      = '0;
                rs2      = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/dispatch_pkg.sv */
`default_nettype none

package dispatch_pkg;

    // RISC-V major opcodes, bits 6:0 of the instruction word.
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_system = 7'b1110011
    } opcode_e;

    // Operation class handed to the back end.
    // op_alu is zero so an idle slot reads as all zero.
    typedef enum logic [2:0] {
        op_alu         = 3'd0,
        op_load        = 3'd1,
        op_store       = 3'd2,
        op_cond_branch = 3'd3,
        op_jump        = 3'd4,
        op_other       = 3'd5
    } op_class_e;

    // True for any class that needs a branch stack entry.
    function automatic logic is_branch(op_class_e op_class);
        return (op_class == op_cond_branch) || (op_class == op_jump);
    endfunction

endpackage

`default_nettype wire

/* verilog/dispatch_cfg.svh */
`ifndef DISPATCH_CFG_SVH
`define DISPATCH_CFG_SVH

// Slots in one fetch group and in one dispatch group.
`define DISPATCH_WIDTH 4

// Entries in the instruction queue. Must be a power of two so pointers wrap on their own.
`define QUEUE_DEPTH 16

// Width of a count that runs from zero up to the full group.
`define COUNT_W ($clog2(`DISPATCH_WIDTH + 1))

// Width of a queue pointer.
`define PTR_W ($clog2(`QUEUE_DEPTH))

// Occupancy needs one bit more than a pointer to hold a full queue.
`define OCC_W (`PTR_W + 1)

`endif
